//--- bench/ddr_controller_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_config.svh"

module ddr_controller_properties (
  input logic        CLK,
  input logic        RST,
  input logic        CKE,
  input logic [2:0]  COMMAND,
  input logic [12:0] ADDRESS,
  input logic [1:0]  BANK,
  input logic        user_req_ack
);

  localparam int HIST = `DDR_T_RP - 1;

  logic [2:0] cmd_hist  [HIST];
  logic [1:0] bank_hist [HIST];
  logic       a10_hist  [HIST];
  logic       pre_conflict;

  // Last few commands, entry 0 is the previous cycle
  always_ff @(posedge CLK)
  begin
    cmd_hist[0]  <= COMMAND;
    bank_hist[0] <= BANK;
    a10_hist[0]  <= ADDRESS[10];
    for (int k = 1; k < HIST; k++)
    begin
      cmd_hist[k]  <= cmd_hist[k-1];
      bank_hist[k] <= bank_hist[k-1];
      a10_hist[k]  <= a10_hist[k-1];
    end
  end

  always_comb
  begin
    pre_conflict = 1'b0;
    for (int k = 0; k < HIST; k++)
    begin
      if (cmd_hist[k] == ddr_cmd_pkg::CMD_PRECHARGE && (a10_hist[k] || bank_hist[k] == BANK))
      begin
        pre_conflict = 1'b1;
      end
    end
  end

  a_cke_low_nop: assert property (@(posedge CLK) disable iff (!RST)
    !CKE |-> COMMAND == ddr_cmd_pkg::CMD_NOP)
    else $error("command issued while CKE is low");

  a_ack_pulse: assert property (@(posedge CLK) disable iff (!RST)
    user_req_ack |=> !user_req_ack)
    else $error("user_req_ack held longer than one cycle");

  a_rp_gap: assert property (@(posedge CLK) disable iff (!RST)
    COMMAND == ddr_cmd_pkg::CMD_ACTIVE |-> !pre_conflict)
    else $error("ACTIVE too soon after PRECHARGE of the same bank");

endmodule

`default_nettype wire

//--- bench/ddr_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_config.svh"

module ddr_controller_tb;

  logic        CLK;
  logic        RST;
  logic        CKE;
  logic [2:0]  COMMAND;
  logic [12:0] ADDRESS;
  logic [1:0]  BANK;
  logic [15:0] dq_out;
  logic [15:0] dq_in;
  logic        dq_oe;
  logic        DM;
  logic        CS;
  logic [25:0] user_req_address;
  logic        user_req_we;
  logic        user_req;
  logic [31:0] user_req_datain;
  logic        user_req_ack;
  logic [31:0] user_req_dataout;

  logic [31:0] shadow_mem [logic [25:0]];
  logic [31:0] rng_state;
  logic [2:0]  init_cmd  [4];
  logic [12:0] init_addr [4];
  logic [2:0]  prev_cmd1;
  logic [2:0]  prev_cmd2;
  int          init_cmds;
  int          refresh_count;
  int          write_count;
  int          oe_count;
  int          cycles_since_init;
  int          reads_after_refresh;

  ddr_cmd_pkg::ddr_addr_word_u mode_word;

  ddr_memory_controller u_dut (
    .CLK              (CLK),
    .RST              (RST),
    .CKE              (CKE),
    .COMMAND          (COMMAND),
    .ADDRESS          (ADDRESS),
    .BANK             (BANK),
    .dq_out           (dq_out),
    .dq_oe            (dq_oe),
    .dq_in            (dq_in),
    .DM               (DM),
    .CS               (CS),
    .user_req_address (user_req_address),
    .user_req_we      (user_req_we),
    .user_req         (user_req),
    .user_req_datain  (user_req_datain),
    .user_req_ack     (user_req_ack),
    .user_req_dataout (user_req_dataout)
  );

  ddr_memory_model u_model (
    .CLK     (CLK),
    .CKE     (CKE),
    .COMMAND (COMMAND),
    .ADDRESS (ADDRESS),
    .BANK    (BANK),
    .dq_out  (dq_out),
    .dq_oe   (dq_oe),
    .dq_in   (dq_in)
  );

  bind ddr_memory_controller ddr_controller_properties u_properties (
    .CLK          (CLK),
    .RST          (RST),
    .CKE          (CKE),
    .COMMAND      (COMMAND),
    .ADDRESS      (ADDRESS),
    .BANK         (BANK),
    .user_req_ack (user_req_ack)
  );

  // Last written word, else the device power-up pattern
  function automatic logic [31:0] expected_word(input logic [25:0] addr);
    logic [24:0] beat_lo;
    logic [24:0] beat_hi;
    if (shadow_mem.exists(addr))
    begin
      return shadow_mem[addr];
    end
    beat_lo = {addr[25:2], 1'b0};
    beat_hi = {addr[25:2], 1'b1};
    return {~beat_hi[15:0], beat_lo[15:0]};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at first error");
    end
  endtask

  // Called at a falling edge, returns at the falling edge after the ack cycle
  task automatic do_request(input logic we, input logic [25:0] addr, input logic [31:0] data);
    int n;
    user_req         = 1'b1;
    user_req_we      = we;
    user_req_address = addr;
    user_req_datain  = data;
    n = 0;
    while (!user_req_ack)
    begin
      @(negedge CLK);
      n++;
      if (n > 400)
      begin
        stop_with_error("request was never acknowledged");
      end
    end
    if (we)
    begin
      shadow_mem[addr] = data;
    end
    // Inputs stay put through the ack cycle, only the request drops
    user_req = 1'b0;
    @(negedge CLK);
  endtask

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Bus monitor and read comparison
  always @(posedge CLK)
  begin
    if (RST)
    begin
      // Single device, always selected and never masked
      check_value("DM", 32'(DM), 32'd0);
      check_value("CS", 32'(CS), 32'd0);

      if (COMMAND != ddr_cmd_pkg::CMD_NOP)
      begin
        if (init_cmds < 4)
        begin
          init_cmd[init_cmds]  = COMMAND;
          init_addr[init_cmds] = ADDRESS;
          init_cmds++;
        end
        else if (COMMAND == ddr_cmd_pkg::CMD_REFRESH)
        begin
          refresh_count++;
        end
        if (COMMAND == ddr_cmd_pkg::CMD_WRITE)
        begin
          write_count++;
        end
      end
      if (init_cmds == 4)
      begin
        cycles_since_init++;
      end
      if (dq_oe)
      begin
        oe_count++;
        if (prev_cmd1 != ddr_cmd_pkg::CMD_WRITE && prev_cmd2 != ddr_cmd_pkg::CMD_WRITE)
        begin
          stop_with_error("dq_oe high outside the two cycles after a WRITE");
        end
      end
      prev_cmd2 = prev_cmd1;
      prev_cmd1 = COMMAND;

      if (user_req_ack && !user_req_we)
      begin
        check_value("user_req_dataout", user_req_dataout, expected_word(user_req_address));
        if (refresh_count > 0)
        begin
          reads_after_refresh++;
        end
      end
    end
  end

  initial
  begin
    int n;
    logic [25:0] addr;
    logic [31:0] data;
    RST                 = 1'b0;
    user_req            = 1'b0;
    user_req_we         = 1'b0;
    user_req_address    = '0;
    user_req_datain     = '0;
    rng_state           = 32'd28259;
    init_cmds           = 0;
    refresh_count       = 0;
    write_count         = 0;
    oe_count            = 0;
    cycles_since_init   = 0;
    reads_after_refresh = 0;
    prev_cmd1           = ddr_cmd_pkg::CMD_NOP;
    prev_cmd2           = ddr_cmd_pkg::CMD_NOP;

    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;

    n = 0;
    while (init_cmds < 4)
    begin
      @(negedge CLK);
      n++;
      if (n > `DDR_INIT_WAIT + 200)
      begin
        stop_with_error("initialization commands did not appear");
      end
    end

    // Power-up order and mode register fields
    check_value("COMMAND", 32'(init_cmd[0]), 32'(ddr_cmd_pkg::CMD_PRECHARGE));
    check_value("ADDRESS[10]", 32'(init_addr[0][10]), 32'd1);
    check_value("COMMAND", 32'(init_cmd[1]), 32'(ddr_cmd_pkg::CMD_LOAD_MODE));
    mode_word = init_addr[1];
    check_value("ADDRESS cas_lat", 32'(mode_word.mode.cas_lat), 32'(`DDR_CAS));
    check_value("ADDRESS burst_len", 32'(mode_word.mode.burst_len), 32'(ddr_cmd_pkg::MODE_BL2));
    check_value("COMMAND", 32'(init_cmd[2]), 32'(ddr_cmd_pkg::CMD_REFRESH));
    check_value("COMMAND", 32'(init_cmd[3]), 32'(ddr_cmd_pkg::CMD_REFRESH));

    do_request(1'b1, 26'h0012344, 32'hCAFE_F00D);
    do_request(1'b0, 26'h0012344, 32'h0);

    // Few rows per bank so hits, misses and closed banks all occur
    for (int i = 0; i < 200; i++)
    begin
      rng_state = lcg_next(rng_state);
      addr      = {11'd0, rng_state[25:24], rng_state[21:20], 6'd0, rng_state[18:16], 2'b00};
      rng_state = lcg_next(rng_state);
      data      = rng_state;
      rng_state = lcg_next(rng_state);
      do_request(rng_state[28], addr, data);
    end

    // Let the last write beats drain
    repeat (4) @(negedge CLK);

    check_value("dq_oe cycles", 32'(oe_count), 32'(2 * write_count));
    if (refresh_count == 0)
    begin
      stop_with_error("no REFRESH command was seen after initialization");
    end
    if (refresh_count < cycles_since_init / `DDR_REFRESH_INTERVAL - 1)
    begin
      stop_with_error("too few REFRESH commands for the elapsed time");
    end
    if (reads_after_refresh == 0)
    begin
      stop_with_error("no read was checked after a refresh");
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/ddr_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_config.svh"

module ddr_memory_model (
  input  logic        CLK,
  input  logic        CKE,
  input  logic [2:0]  COMMAND,
  input  logic [12:0] ADDRESS,
  input  logic [1:0]  BANK,
  input  logic [15:0] dq_out,
  input  logic        dq_oe,
  output logic [15:0] dq_in
);

  logic [12:0] open_row [4];
  logic [3:0]  bank_open;
  logic        rd_closed;
  logic [15:0] mem [logic [24:0]];
  logic [24:0] rd_key;
  logic [24:0] wr_key;
  int          rd_age;
  int          wr_age;

  ddr_cmd_pkg::ddr_addr_word_u addr_word;

  // Beat address is {row, bank, column}, the high beat of a word holds the inverted pattern
  function automatic logic [15:0] read_beat(input logic [24:0] key);
    if (mem.exists(key))
    begin
      return mem[key];
    end
    return key[0] ? ~key[15:0] : key[15:0];
  endfunction

  assign addr_word = ADDRESS;

  initial
  begin
    dq_in     = '0;
    rd_age    = -1;
    wr_age    = -1;
    bank_open = '0;
    rd_closed = 1'b0;
  end

  always @(posedge CLK)
  begin
    // Read beats appear CAS latency cycles after the READ command
    // A read from a closed bank returns corrupted data
    if (rd_age >= 0)
    begin
      if (rd_age == `DDR_CAS - 2)
      begin
        dq_in <= rd_closed ? ~read_beat(rd_key) : read_beat(rd_key);
      end
      if (rd_age == `DDR_CAS - 1)
      begin
        dq_in <= rd_closed ? ~read_beat(rd_key | 25'd1) : read_beat(rd_key | 25'd1);
      end
      rd_age <= (rd_age == `DDR_CAS - 1) ? -1 : rd_age + 1;
    end

    // Write beats follow the WRITE command on the next two cycles
    if (wr_age >= 0 && dq_oe)
    begin
      mem[wr_key | 25'(wr_age)] = dq_out;
    end
    if (wr_age >= 0)
    begin
      wr_age <= (wr_age == 1) ? -1 : wr_age + 1;
    end

    if (CKE)
    begin
      case (COMMAND)
        ddr_cmd_pkg::CMD_ACTIVE:
        begin
          open_row[BANK]  <= ADDRESS;
          bank_open[BANK] <= 1'b1;
        end
        ddr_cmd_pkg::CMD_PRECHARGE:
        begin
          // A10 closes every bank
          if (addr_word.col_view.auto_pre)
          begin
            bank_open <= '0;
          end
          else
          begin
            bank_open[BANK] <= 1'b0;
          end
        end
        ddr_cmd_pkg::CMD_READ:
        begin
          rd_key    <= {open_row[BANK], BANK, addr_word.col_view.col};
          rd_closed <= !bank_open[BANK];
          rd_age    <= 0;
        end
        ddr_cmd_pkg::CMD_WRITE:
        begin
          wr_key <= {open_row[BANK], BANK, addr_word.col_view.col};
          wr_age <= 0;
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/ddr_cmd_pkg.sv
logic/ddr_map_pkg.sv
logic/ddr_refresh_timer.sv
logic/ddr_init_sequencer.sv
logic/ddr_bank_sequencer.sv
logic/ddr_data_path.sv
logic/ddr_memory_controller.sv
bench/ddr_memory_model.sv
bench/ddr_controller_properties.sv
bench/ddr_controller_tb.sv

//--- logic/ddr_bank_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_config.svh"

module ddr_bank_sequencer (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           init_done,
  input  logic                           refresh_strobe,
  input  logic                           user_req,
  input  logic                           user_req_we,
  input  logic [ddr_map_pkg::ADDR_W-1:0] user_req_address,
  input  logic                           read_done,
  output logic                           user_req_ack,
  output logic [2:0]                     cmd_user,
  output logic [12:0]                    addr_user,
  output logic [1:0]                     bank_user,
  output logic                           cmd_issued,
  output logic                           cmd_is_write
);

  localparam int NUM_BANKS = 1 << ddr_map_pkg::BANK_W;
  localparam int WAIT_W    = $clog2(`DDR_T_RFC + 1);

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_ACT       = 3'd1;
  localparam logic [2:0] S_ACCESS    = 3'd2;
  localparam logic [2:0] S_WAIT_READ = 3'd3;
  localparam logic [2:0] S_REF       = 3'd4;
  localparam logic [2:0] S_GAP       = 3'd5;

  logic [2:0]                      state_q;
  logic [WAIT_W-1:0]               wait_q;
  logic                            refresh_pending_q;
  logic                            ack_wr_q;
  logic [NUM_BANKS-1:0]            open_q;
  logic [ddr_map_pkg::ROW_W-1:0]   open_row_q [NUM_BANKS];

  logic [ddr_map_pkg::ROW_W-1:0]   req_row;
  logic [ddr_map_pkg::BANK_W-1:0]  req_bank;
  logic [ddr_map_pkg::COL_W-1:0]   req_col;
  logic                            ready;
  logic                            new_req;
  logic                            issue_act;
  logic                            issue_access;

  ddr_cmd_pkg::ddr_addr_word_u row_word;
  ddr_cmd_pkg::ddr_addr_word_u col_word;
  ddr_cmd_pkg::ddr_addr_word_u pre_word;

  assign req_row  = user_req_address[ddr_map_pkg::ROW_LSB +: ddr_map_pkg::ROW_W];
  assign req_bank = user_req_address[ddr_map_pkg::BANK_LSB +: ddr_map_pkg::BANK_W];
  assign req_col  = user_req_address[ddr_map_pkg::COL_LSB +: ddr_map_pkg::COL_W];

  // Refresh wins over a new request
  assign ready   = init_done && (wait_q == '0);
  assign new_req = ready && (state_q == S_IDLE) && !refresh_pending_q && user_req;

  assign issue_act    = (new_req && !open_q[req_bank]) || (ready && state_q == S_ACT);
  assign issue_access = (new_req && open_q[req_bank] && open_row_q[req_bank] == req_row)
                     || (ready && state_q == S_ACCESS);

  // Reads are acknowledged together with the returned word
  assign user_req_ack = ack_wr_q | read_done;

  always_comb
  begin
    row_word     = '0;
    row_word.row = req_row;

    // Device column counts 16-bit beats
    col_word              = '0;
    col_word.col_view.col = {req_col, 1'b0};

    pre_word                   = '0;
    pre_word.col_view.auto_pre = 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (issue_act)
    begin
      open_row_q[req_bank] <= req_row;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state_q           <= S_IDLE;
      wait_q            <= '0;
      refresh_pending_q <= 1'b0;
      ack_wr_q          <= 1'b0;
      open_q            <= '0;
      cmd_user          <= ddr_cmd_pkg::CMD_NOP;
      addr_user         <= '0;
      bank_user         <= '0;
      cmd_issued        <= 1'b0;
      cmd_is_write      <= 1'b0;
    end
    else
    begin
      cmd_user   <= ddr_cmd_pkg::CMD_NOP;
      cmd_issued <= 1'b0;
      ack_wr_q   <= 1'b0;

      if (wait_q != '0)
      begin
        wait_q <= wait_q - 1'b1;
      end
      else if (issue_act)
      begin
        cmd_user         <= ddr_cmd_pkg::CMD_ACTIVE;
        addr_user        <= row_word;
        bank_user        <= req_bank;
        open_q[req_bank] <= 1'b1;
        wait_q           <= WAIT_W'(`DDR_T_RCD - 1);
        state_q          <= S_ACCESS;
      end
      else if (issue_access)
      begin
        cmd_user     <= user_req_we ? ddr_cmd_pkg::CMD_WRITE : ddr_cmd_pkg::CMD_READ;
        addr_user    <= col_word;
        bank_user    <= req_bank;
        cmd_issued   <= 1'b1;
        cmd_is_write <= user_req_we;
        ack_wr_q     <= user_req_we;
        state_q      <= user_req_we ? S_IDLE : S_WAIT_READ;
      end
      else if (init_done)
      begin
        case (state_q)
          S_IDLE:
          begin
            if (refresh_pending_q && (|open_q))
            begin
              // Close every bank before refresh
              cmd_user  <= ddr_cmd_pkg::CMD_PRECHARGE;
              addr_user <= pre_word;
              wait_q    <= WAIT_W'(`DDR_T_RP - 1);
              state_q   <= S_REF;
            end
            else if (refresh_pending_q)
            begin
              cmd_user          <= ddr_cmd_pkg::CMD_REFRESH;
              refresh_pending_q <= 1'b0;
              wait_q            <= WAIT_W'(`DDR_T_RFC - 1);
              state_q           <= S_GAP;
            end
            else if (user_req)
            begin
              // Row miss, the open row goes first
              cmd_user         <= ddr_cmd_pkg::CMD_PRECHARGE;
              addr_user        <= '0;
              bank_user        <= req_bank;
              open_q[req_bank] <= 1'b0;
              wait_q           <= WAIT_W'(`DDR_T_RP - 1);
              state_q          <= S_ACT;
            end
          end
          S_REF:
          begin
            cmd_user          <= ddr_cmd_pkg::CMD_REFRESH;
            refresh_pending_q <= 1'b0;
            open_q            <= '0;
            wait_q            <= WAIT_W'(`DDR_T_RFC - 1);
            state_q           <= S_GAP;
          end
          S_WAIT_READ:
          begin
            if (read_done)
            begin
              state_q <= S_IDLE;
            end
          end
          default:
          begin
            state_q <= S_IDLE;
          end
        endcase
      end

      if (refresh_strobe)
      begin
        refresh_pending_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ddr_cmd_pkg.sv
`default_nettype none

package ddr_cmd_pkg;

  // Device commands as {RAS, CAS, WE}
  localparam logic [2:0] CMD_NOP       = 3'b111;
  localparam logic [2:0] CMD_ACTIVE    = 3'b011;
  localparam logic [2:0] CMD_READ      = 3'b101;
  localparam logic [2:0] CMD_WRITE     = 3'b100;
  localparam logic [2:0] CMD_PRECHARGE = 3'b010;
  localparam logic [2:0] CMD_REFRESH   = 3'b001;
  localparam logic [2:0] CMD_LOAD_MODE = 3'b000;

  // Mode register field values
  localparam logic [2:0] MODE_BL2        = 3'b001;
  localparam logic       MODE_SEQUENTIAL = 1'b0;

  // One address word, read as row, column or mode register
  typedef union packed {
    logic [12:0] row;
    struct packed {
      logic [1:0] unused;
      logic       auto_pre;
      logic [9:0] col;
    } col_view;
    struct packed {
      logic [5:0] op_mode;
      logic [2:0] cas_lat;
      logic       burst_type;
      logic [2:0] burst_len;
    } mode;
  } ddr_addr_word_u;

endpackage

`default_nettype wire

//--- logic/ddr_config.svh
`ifndef DDR_CONFIG_SVH
`define DDR_CONFIG_SVH

// Cycles of CKE low after reset before the first command
`define DDR_INIT_WAIT 100

// Precharge to activate gap, also used after mode load
`define DDR_T_RP 3

// Activate to read or write gap
`define DDR_T_RCD 3

// Refresh cycle time
`define DDR_T_RFC 8

// CAS latency in CLK cycles
`define DDR_CAS 2

// Cycles between refresh requests
`define DDR_REFRESH_INTERVAL 256

`endif

//--- logic/ddr_data_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_config.svh"

module ddr_data_path (
  input  logic        CLK,
  input  logic        RST,
  input  logic        cmd_issued,
  input  logic        cmd_is_write,
  input  logic [31:0] user_req_datain,
  input  logic [15:0] dq_in,
  output logic [15:0] dq_out,
  output logic        dq_oe,
  output logic [31:0] user_req_dataout,
  output logic        read_done
);

  // Command reaches the pins one cycle after cmd_issued
  localparam int RD_DEPTH = `DDR_CAS + 2;

  logic [RD_DEPTH-1:0] rd_sr;
  logic [1:0]          wr_sr;
  logic [31:0]         wdata_q;
  logic [15:0]         rd_low_q;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      rd_sr     <= '0;
      wr_sr     <= '0;
      dq_oe     <= 1'b0;
      read_done <= 1'b0;
    end
    else
    begin
      rd_sr     <= {rd_sr[RD_DEPTH-2:0], cmd_issued & ~cmd_is_write};
      wr_sr     <= {wr_sr[0], cmd_issued & cmd_is_write};
      dq_oe     <= |wr_sr;
      read_done <= rd_sr[RD_DEPTH-1];
    end
  end

  always_ff @(posedge CLK)
  begin
    // Write word is taken in the ack cycle
    if (cmd_issued && cmd_is_write)
    begin
      wdata_q <= user_req_datain;
    end

    // Low half first, then high half
    if (wr_sr[0])
    begin
      dq_out <= wdata_q[15:0];
    end
    else if (wr_sr[1])
    begin
      dq_out <= wdata_q[31:16];
    end

    if (rd_sr[RD_DEPTH-2])
    begin
      rd_low_q <= dq_in;
    end
    if (rd_sr[RD_DEPTH-1])
    begin
      user_req_dataout <= {dq_in, rd_low_q};
    end
  end

endmodule

`default_nettype wire

//--- logic/ddr_init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_config.svh"

module ddr_init_sequencer (
  input  logic        CLK,
  input  logic        RST,
  output logic        CKE,
  output logic [2:0]  COMMAND,
  output logic [12:0] ADDRESS,
  output logic [1:0]  BANK,
  input  logic [2:0]  cmd_user,
  input  logic [12:0] addr_user,
  input  logic [1:0]  bank_user,
  output logic        init_done
);

  localparam int WAIT_W = $clog2(`DDR_INIT_WAIT + 1);

  logic [2:0]        step_q;
  logic [WAIT_W-1:0] wait_q;

  ddr_cmd_pkg::ddr_addr_word_u pre_all_word;
  ddr_cmd_pkg::ddr_addr_word_u mode_word;

  always_comb
  begin
    pre_all_word                   = '0;
    pre_all_word.col_view.auto_pre = 1'b1;

    mode_word                 = '0;
    mode_word.mode.cas_lat    = 3'(`DDR_CAS);
    mode_word.mode.burst_type = ddr_cmd_pkg::MODE_SEQUENTIAL;
    mode_word.mode.burst_len  = ddr_cmd_pkg::MODE_BL2;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      step_q    <= '0;
      wait_q    <= WAIT_W'(`DDR_INIT_WAIT - 1);
      CKE       <= 1'b0;
      COMMAND   <= ddr_cmd_pkg::CMD_NOP;
      ADDRESS   <= '0;
      BANK      <= '0;
      init_done <= 1'b0;
    end
    else if (init_done)
    begin
      // Pins now belong to the bank sequencer
      COMMAND <= cmd_user;
      ADDRESS <= addr_user;
      BANK    <= bank_user;
    end
    else
    begin
      COMMAND <= ddr_cmd_pkg::CMD_NOP;
      if (wait_q != '0)
      begin
        wait_q <= wait_q - 1'b1;
      end
      else
      begin
        step_q <= step_q + 1'b1;
        case (step_q)
          3'd0:
          begin
            CKE    <= 1'b1;
            wait_q <= WAIT_W'(`DDR_T_RP - 1);
          end
          3'd1:
          begin
            COMMAND <= ddr_cmd_pkg::CMD_PRECHARGE;
            ADDRESS <= pre_all_word;
            wait_q  <= WAIT_W'(`DDR_T_RP - 1);
          end
          3'd2:
          begin
            COMMAND <= ddr_cmd_pkg::CMD_LOAD_MODE;
            ADDRESS <= mode_word;
            BANK    <= '0;
            wait_q  <= WAIT_W'(`DDR_T_RP - 1);
          end
          // Two refresh commands close the sequence
          3'd3, 3'd4:
          begin
            COMMAND <= ddr_cmd_pkg::CMD_REFRESH;
            wait_q  <= WAIT_W'(`DDR_T_RFC - 1);
          end
          default:
          begin
            init_done <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ddr_map_pkg.sv
`default_nettype none

package ddr_map_pkg;

  // User word address split into row, bank and column
  localparam int ROW_LSB  = 13;
  localparam int ROW_W    = 13;
  localparam int BANK_LSB = 11;
  localparam int BANK_W   = 2;

  // Column of a 32-bit word, bits 1:0 select a byte and are not used
  localparam int COL_LSB  = 2;
  localparam int COL_W    = 9;

  localparam int ADDR_W   = 26;

endpackage

`default_nettype wire

//--- logic/ddr_memory_controller.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_memory_controller (
  input  logic                           CLK,
  input  logic                           RST,
  output logic                           CKE,
  output logic [2:0]                     COMMAND,
  output logic [12:0]                    ADDRESS,
  output logic [1:0]                     BANK,
  output logic [15:0]                    dq_out,
  output logic                           dq_oe,
  input  logic [15:0]                    dq_in,
  output logic                           DM,
  output logic                           CS,
  input  logic [ddr_map_pkg::ADDR_W-1:0] user_req_address,
  input  logic                           user_req_we,
  input  logic                           user_req,
  input  logic [31:0]                    user_req_datain,
  output logic                           user_req_ack,
  output logic [31:0]                    user_req_dataout
);

  logic [2:0]  cmd_user;
  logic [12:0] addr_user;
  logic [1:0]  bank_user;
  logic        init_done;
  logic        refresh_strobe;
  logic        cmd_issued;
  logic        cmd_is_write;
  logic        read_done;

  // Single device, always selected, no byte masking
  assign CS = 1'b0;
  assign DM = 1'b0;

  ddr_refresh_timer u_refresh_timer (
    .CLK            (CLK),
    .RST            (RST),
    .init_done      (init_done),
    .refresh_strobe (refresh_strobe)
  );

  ddr_init_sequencer u_init_sequencer (
    .CLK       (CLK),
    .RST       (RST),
    .CKE       (CKE),
    .COMMAND   (COMMAND),
    .ADDRESS   (ADDRESS),
    .BANK      (BANK),
    .cmd_user  (cmd_user),
    .addr_user (addr_user),
    .bank_user (bank_user),
    .init_done (init_done)
  );

  ddr_bank_sequencer u_bank_sequencer (
    .CLK              (CLK),
    .RST              (RST),
    .init_done        (init_done),
    .refresh_strobe   (refresh_strobe),
    .user_req         (user_req),
    .user_req_we      (user_req_we),
    .user_req_address (user_req_address),
    .read_done        (read_done),
    .user_req_ack     (user_req_ack),
    .cmd_user         (cmd_user),
    .addr_user        (addr_user),
    .bank_user        (bank_user),
    .cmd_issued       (cmd_issued),
    .cmd_is_write     (cmd_is_write)
  );

  ddr_data_path u_data_path (
    .CLK              (CLK),
    .RST              (RST),
    .cmd_issued       (cmd_issued),
    .cmd_is_write     (cmd_is_write),
    .user_req_datain  (user_req_datain),
    .dq_in            (dq_in),
    .dq_out           (dq_out),
    .dq_oe            (dq_oe),
    .user_req_dataout (user_req_dataout),
    .read_done        (read_done)
  );

endmodule

`default_nettype wire

//--- logic/ddr_refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ddr_config.svh"

module ddr_refresh_timer (
  input  logic CLK,
  input  logic RST,
  input  logic init_done,
  output logic refresh_strobe
);

  localparam int CNT_W = $clog2(`DDR_REFRESH_INTERVAL);

  logic [CNT_W-1:0] count_q;

  // Held at zero until the device is initialized
  always_ff @(posedge CLK)
  begin
    if (!RST || !init_done)
    begin
      count_q        <= '0;
      refresh_strobe <= 1'b0;
    end
    else
    begin
      refresh_strobe <= 1'b0;
      if (count_q == CNT_W'(`DDR_REFRESH_INTERVAL - 1))
      begin
        count_q        <= '0;
        refresh_strobe <= 1'b1;
      end
      else
      begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Compile with Verilator and run the DDR controller testbench

verilator --binary --timing --assert -f flist.f --top-module ddr_controller_tb -o ddr_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

out=$(./obj_dir/ddr_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with an error status"
  exit 1
fi

if echo "$out" | grep -q "TEST OK"; then
  exit 0
fi
exit 1
